// ==== source/exu_params.svh ====
// widths and constants shared by the execute unit
`ifndef EXU_PARAMS_SVH
`define EXU_PARAMS_SVH

// data word width
`define EXU_XLEN 32

// register index width
`define EXU_REG_ADDR_W 5

// id of an instruction as it leaves issue
`define EXU_INST_ID_W 2

// id that goes back with a writeback
`define EXU_COMMIT_ID_W 4

// divider iterations, one quotient bit each
`define EXU_DIV_CYCLES 32

`endif

// ==== source/exu_pkg.sv ====
// data typedefs, operation enum and divider state enum
`include "exu_params.svh"

package exu_pkg;

    typedef logic [`EXU_XLEN-1:0]        xlen_t;
    typedef logic [`EXU_REG_ADDR_W-1:0]  reg_addr_t;
    typedef logic [`EXU_COMMIT_ID_W-1:0] commit_id_t;
    typedef logic [`EXU_INST_ID_W-1:0]   inst_id_t;

    // compact operation code from decode
    typedef enum logic [4:0] {
        OP_NONE,
        // alu
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
        // branches and jumps
        BEQ, BNE, BLT, BGE, BLTU, BGEU, JAL, JALR,
        // multiply and divide
        MUL, MULH, MULHSU, MULHU, DIV, DIVU, REM, REMU
    } exu_op_e;

    typedef enum logic [1:0] {
        IDLE,
        CALC,
        DONE
    } div_state_e;

endpackage

// ==== source/exu_dispatch.sv ====
// unit routing, second operand select and issue stall
`timescale 1ns/1ps

module exu_dispatch (
    input  logic             valid_i,
    input  exu_pkg::exu_op_e op_i,
    input  logic             use_imm_i,
    input  exu_pkg::xlen_t   imm_i,
    input  exu_pkg::xlen_t   rs2_data_i,
    input  logic             int_assert_i,
    input  logic             alu_busy_i,
    input  logic             muldiv_busy_i,
    output logic             alu_req_o,
    output logic             bru_req_o,
    output logic             muldiv_req_o,
    output exu_pkg::xlen_t   op2_o,
    output logic             stall_o
);
    import exu_pkg::*;

    logic is_alu;
    logic is_bru;
    logic is_link;
    logic is_muldiv;
    logic accept;

    assign is_alu    = op_i inside {[ADD:AND]};
    assign is_bru    = op_i inside {[BEQ:JALR]};
    assign is_muldiv = op_i inside {[MUL:REMU]};
    // jumps also need the alu slot for the link value
    assign is_link   = (op_i == JAL) || (op_i == JALR);

    // only the targeted unit can hold issue back
    assign stall_o = valid_i &
                     (((is_alu | is_link) & alu_busy_i) | (is_muldiv & muldiv_busy_i));

    // a pending interrupt takes the slot, nothing issues
    assign accept = valid_i & ~stall_o & ~int_assert_i;

    assign alu_req_o    = accept & is_alu;
    assign bru_req_o    = accept & is_bru;
    assign muldiv_req_o = accept & is_muldiv;

    assign op2_o = use_imm_i ? imm_i : rs2_data_i;

    // an accepted instruction goes to exactly one unit
    always_comb begin
        assert (!accept || $onehot({alu_req_o, bru_req_o, muldiv_req_o}))
        else $error("accepted instruction did not reach exactly one unit");
    end

endmodule

// ==== source/exu_alu.sv ====
// integer ALU with a one-entry writeback slot
`timescale 1ns/1ps

module exu_alu (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                req_i,
    input  exu_pkg::exu_op_e    op_i,
    input  exu_pkg::xlen_t      op1_i,
    input  exu_pkg::xlen_t      op2_i,
    input  logic                link_i,
    input  exu_pkg::xlen_t      pc_i,
    input  exu_pkg::reg_addr_t  rd_i,
    input  exu_pkg::inst_id_t   inst_id_i,
    input  logic                wb_ready_i,
    output logic                busy_o,
    output logic                we_o,
    output exu_pkg::reg_addr_t  waddr_o,
    output exu_pkg::xlen_t      wdata_o,
    output exu_pkg::commit_id_t commit_id_o
);
    import exu_pkg::*;

    xlen_t      result;
    logic [4:0] shamt;
    logic       load;
    logic       we_q;
    xlen_t      wdata_q;
    reg_addr_t  waddr_q;
    commit_id_t cid_q;

    assign shamt = op2_i[4:0];
    // jumps write the return address through this port
    assign load  = req_i | link_i;

    always_comb begin
        if (link_i) begin
            result = pc_i + xlen_t'(4);
        end else begin
            case (op_i)
                SUB:     result = op1_i - op2_i;
                SLL:     result = op1_i << shamt;
                SLT:     result = xlen_t'($signed(op1_i) < $signed(op2_i));
                SLTU:    result = xlen_t'(op1_i < op2_i);
                XOR:     result = op1_i ^ op2_i;
                SRL:     result = op1_i >> shamt;
                SRA:     result = $signed(op1_i) >>> shamt;
                OR:      result = op1_i | op2_i;
                AND:     result = op1_i & op2_i;
                default: result = op1_i + op2_i;
            endcase
        end
    end

    // slot stays full until the writeback side takes it
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            we_q <= 1'b0;
        end else if (load) begin
            we_q <= 1'b1;
        end else if (wb_ready_i) begin
            we_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            wdata_q <= result;
            waddr_q <= rd_i;
            cid_q   <= commit_id_t'(inst_id_i);
        end
    end

    assign busy_o      = we_q & ~wb_ready_i;
    assign we_o        = we_q;
    assign waddr_o     = waddr_q;
    assign wdata_o     = wdata_q;
    assign commit_id_o = cid_q;

    // dispatch must not overwrite a result that is still waiting
    assert property (@(posedge clk) disable iff (!rst_n_i)
        we_o && !wb_ready_i |=> $stable(wdata_o));

endmodule

// ==== source/exu_bru.sv ====
// branch compare, jump target, link request and interrupt redirect
`timescale 1ns/1ps
`include "exu_params.svh"

module exu_bru (
    input  logic             req_i,
    input  exu_pkg::exu_op_e op_i,
    input  exu_pkg::xlen_t   rs1_i,
    input  exu_pkg::xlen_t   rs2_i,
    input  exu_pkg::xlen_t   pc_i,
    input  exu_pkg::xlen_t   imm_i,
    input  logic             int_assert_i,
    input  exu_pkg::xlen_t   int_addr_i,
    output logic             jump_flag_o,
    output exu_pkg::xlen_t   jump_addr_o,
    output logic             link_o
);
    import exu_pkg::*;

    logic  taken;
    logic  is_jump;
    xlen_t jalr_sum;
    xlen_t target;

    always_comb begin
        case (op_i)
            BEQ:       taken = rs1_i == rs2_i;
            BNE:       taken = rs1_i != rs2_i;
            BLT:       taken = $signed(rs1_i) < $signed(rs2_i);
            BGE:       taken = $signed(rs1_i) >= $signed(rs2_i);
            BLTU:      taken = rs1_i < rs2_i;
            BGEU:      taken = rs1_i >= rs2_i;
            JAL, JALR: taken = 1'b1;
            default:   taken = 1'b0;
        endcase
    end

    assign is_jump  = (op_i == JAL) || (op_i == JALR);
    // jalr target has bit 0 forced low
    assign jalr_sum = rs1_i + imm_i;
    assign target   = (op_i == JALR) ? {jalr_sum[`EXU_XLEN-1:1], 1'b0} : pc_i + imm_i;

    assign link_o = req_i & is_jump;

    // interrupt wins over any branch in flight
    assign jump_flag_o = int_assert_i | (req_i & taken);
    assign jump_addr_o = int_assert_i ? int_addr_i : target;

endmodule

// ==== source/exu_div.sv ====
// iterative restoring divider, signed and unsigned, quotient or remainder
`timescale 1ns/1ps
`include "exu_params.svh"

module exu_div (
    input  logic           clk,
    input  logic           rst_n_i,
    input  logic           start_i,
    input  logic           signed_i,
    input  logic           rem_i,
    input  exu_pkg::xlen_t dividend_i,
    input  exu_pkg::xlen_t divisor_i,
    output logic           busy_o,
    output logic           valid_o,
    output exu_pkg::xlen_t result_o
);
    import exu_pkg::*;

    localparam int unsigned CNT_W = $clog2(`EXU_DIV_CYCLES);

    div_state_e         state_q;
    logic [CNT_W-1:0]   cnt_q;
    xlen_t              quo_q;
    xlen_t              rem_q;
    xlen_t              dvsr_q;
    logic               neg_quo_q;
    logic               neg_rem_q;
    logic               rem_sel_q;
    logic               a_neg;
    logic               b_neg;
    xlen_t              a_mag;
    xlen_t              b_mag;
    logic [`EXU_XLEN:0] shifted;
    logic [`EXU_XLEN:0] diff;

    // work on magnitudes, signs restored at the end
    assign a_neg = signed_i & dividend_i[`EXU_XLEN-1];
    assign b_neg = signed_i & divisor_i[`EXU_XLEN-1];
    assign a_mag = a_neg ? -dividend_i : dividend_i;
    assign b_mag = b_neg ? -divisor_i : divisor_i;

    // next dividend bit shifted into the partial remainder
    assign shifted = {rem_q, quo_q[`EXU_XLEN-1]};
    assign diff    = shifted - {1'b0, dvsr_q};

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        state_q <= CALC;
                        cnt_q   <= '0;
                    end
                end
                CALC: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == CNT_W'(`EXU_DIV_CYCLES - 1)) begin
                        state_q <= DONE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // quo_q starts as the dividend and fills with quotient bits from the right
    always_ff @(posedge clk) begin
        if (start_i && state_q == IDLE) begin
            quo_q     <= a_mag;
            rem_q     <= '0;
            dvsr_q    <= b_mag;
            // divide by zero keeps the all-ones quotient
            neg_quo_q <= (a_neg ^ b_neg) && (divisor_i != '0);
            neg_rem_q <= a_neg;
            rem_sel_q <= rem_i;
        end else if (state_q == CALC) begin
            if (!diff[`EXU_XLEN]) begin
                rem_q <= diff[`EXU_XLEN-1:0];
                quo_q <= {quo_q[`EXU_XLEN-2:0], 1'b1};
            end else begin
                rem_q <= shifted[`EXU_XLEN-1:0];
                quo_q <= {quo_q[`EXU_XLEN-2:0], 1'b0};
            end
        end
    end

    assign busy_o  = state_q != IDLE;
    assign valid_o = state_q == DONE;

    always_comb begin
        if (rem_sel_q) begin
            result_o = neg_rem_q ? -rem_q : rem_q;
        end else begin
            result_o = neg_quo_q ? -quo_q : quo_q;
        end
    end

    // the controller never restarts a divide in flight
    assert property (@(posedge clk) disable iff (!rst_n_i) start_i |-> !busy_o);

endmodule

// ==== source/exu_muldiv.sv ====
// multiply/divide controller, registered multiplier and writeback slot
`timescale 1ns/1ps
`include "exu_params.svh"

module exu_muldiv (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                req_i,
    input  exu_pkg::exu_op_e    op_i,
    input  exu_pkg::xlen_t      rs1_i,
    input  exu_pkg::xlen_t      rs2_i,
    input  exu_pkg::reg_addr_t  rd_i,
    input  exu_pkg::inst_id_t   inst_id_i,
    input  logic                wb_ready_i,
    output logic                busy_o,
    output logic                we_o,
    output exu_pkg::reg_addr_t  waddr_o,
    output exu_pkg::xlen_t      wdata_o,
    output exu_pkg::commit_id_t commit_id_o
);
    import exu_pkg::*;

    logic                     is_mul;
    logic                     is_div;
    logic                     sign_a;
    logic                     sign_b;
    logic [`EXU_XLEN:0]       mul_a;
    logic [`EXU_XLEN:0]       mul_b;
    logic [2*`EXU_XLEN+1:0]   product;
    logic [2*`EXU_XLEN-1:0]   prod_q;
    logic                     hi_sel_q;
    logic                     mul_pend_q;
    logic                     div_start;
    logic                     div_busy;
    logic                     div_valid;
    xlen_t                    div_result;
    logic                     we_q;
    xlen_t                    wdata_q;
    reg_addr_t                rd_q;
    commit_id_t               cid_q;

    assign is_mul = op_i inside {MUL, MULH, MULHSU, MULHU};
    assign is_div = op_i inside {DIV, DIVU, REM, REMU};

    // one extra bit per operand covers all three signedness mixes
    assign sign_a  = (op_i == MULH) || (op_i == MULHSU);
    assign sign_b  = op_i == MULH;
    assign mul_a   = {sign_a & rs1_i[`EXU_XLEN-1], rs1_i};
    assign mul_b   = {sign_b & rs2_i[`EXU_XLEN-1], rs2_i};
    assign product = $signed(mul_a) * $signed(mul_b);

    assign div_start = req_i & is_div;

    exu_div u_div (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .start_i    (div_start),
        .signed_i   ((op_i == DIV) || (op_i == REM)),
        .rem_i      ((op_i == REM) || (op_i == REMU)),
        .dividend_i (rs1_i),
        .divisor_i  (rs2_i),
        .busy_o     (div_busy),
        .valid_o    (div_valid),
        .result_o   (div_result)
    );

    // destination and id are held from issue until the result leaves
    always_ff @(posedge clk) begin
        if (req_i) begin
            rd_q     <= rd_i;
            cid_q    <= commit_id_t'(inst_id_i);
            prod_q   <= product[2*`EXU_XLEN-1:0];
            hi_sel_q <= op_i != MUL;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            mul_pend_q <= 1'b0;
            we_q       <= 1'b0;
        end else begin
            mul_pend_q <= req_i & is_mul;
            if (mul_pend_q || div_valid) begin
                we_q <= 1'b1;
            end else if (wb_ready_i) begin
                we_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mul_pend_q) begin
            wdata_q <= hi_sel_q ? prod_q[2*`EXU_XLEN-1:`EXU_XLEN] : prod_q[`EXU_XLEN-1:0];
        end else if (div_valid) begin
            wdata_q <= div_result;
        end
    end

    // busy through the whole computation and while the slot waits
    assign busy_o      = mul_pend_q | div_busy | (we_q & ~wb_ready_i);
    assign we_o        = we_q;
    assign waddr_o     = rd_q;
    assign wdata_o     = wdata_q;
    assign commit_id_o = cid_q;

endmodule

// ==== source/exu.sv ====
// execute unit top, dispatch plus alu, branch and multiply/divide units
`timescale 1ns/1ps

module exu (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                valid_i,
    input  exu_pkg::exu_op_e    op_i,
    input  logic                use_imm_i,
    input  exu_pkg::xlen_t      pc_i,
    input  exu_pkg::xlen_t      imm_i,
    input  exu_pkg::xlen_t      rs1_data_i,
    input  exu_pkg::xlen_t      rs2_data_i,
    input  exu_pkg::reg_addr_t  rd_i,
    input  exu_pkg::inst_id_t   inst_id_i,
    input  logic                alu_wb_ready_i,
    input  logic                muldiv_wb_ready_i,
    input  logic                int_assert_i,
    input  exu_pkg::xlen_t      int_addr_i,
    output logic                stall_o,
    output logic                alu_we_o,
    output exu_pkg::reg_addr_t  alu_waddr_o,
    output exu_pkg::xlen_t      alu_wdata_o,
    output exu_pkg::commit_id_t alu_commit_id_o,
    output logic                muldiv_we_o,
    output exu_pkg::reg_addr_t  muldiv_waddr_o,
    output exu_pkg::xlen_t      muldiv_wdata_o,
    output exu_pkg::commit_id_t muldiv_commit_id_o,
    output logic                jump_flag_o,
    output exu_pkg::xlen_t      jump_addr_o
);
    import exu_pkg::*;

    logic  alu_req;
    logic  bru_req;
    logic  muldiv_req;
    logic  alu_busy;
    logic  muldiv_busy;
    logic  link;
    xlen_t op2;

    exu_dispatch u_dispatch (
        .valid_i       (valid_i),
        .op_i          (op_i),
        .use_imm_i     (use_imm_i),
        .imm_i         (imm_i),
        .rs2_data_i    (rs2_data_i),
        .int_assert_i  (int_assert_i),
        .alu_busy_i    (alu_busy),
        .muldiv_busy_i (muldiv_busy),
        .alu_req_o     (alu_req),
        .bru_req_o     (bru_req),
        .muldiv_req_o  (muldiv_req),
        .op2_o         (op2),
        .stall_o       (stall_o)
    );

    exu_alu u_alu (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .req_i       (alu_req),
        .op_i        (op_i),
        .op1_i       (rs1_data_i),
        .op2_i       (op2),
        .link_i      (link),
        .pc_i        (pc_i),
        .rd_i        (rd_i),
        .inst_id_i   (inst_id_i),
        .wb_ready_i  (alu_wb_ready_i),
        .busy_o      (alu_busy),
        .we_o        (alu_we_o),
        .waddr_o     (alu_waddr_o),
        .wdata_o     (alu_wdata_o),
        .commit_id_o (alu_commit_id_o)
    );

    // branches compare the raw register values
    exu_bru u_bru (
        .req_i        (bru_req),
        .op_i         (op_i),
        .rs1_i        (rs1_data_i),
        .rs2_i        (rs2_data_i),
        .pc_i         (pc_i),
        .imm_i        (imm_i),
        .int_assert_i (int_assert_i),
        .int_addr_i   (int_addr_i),
        .jump_flag_o  (jump_flag_o),
        .jump_addr_o  (jump_addr_o),
        .link_o       (link)
    );

    exu_muldiv u_muldiv (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .req_i       (muldiv_req),
        .op_i        (op_i),
        .rs1_i       (rs1_data_i),
        .rs2_i       (rs2_data_i),
        .rd_i        (rd_i),
        .inst_id_i   (inst_id_i),
        .wb_ready_i  (muldiv_wb_ready_i),
        .busy_o      (muldiv_busy),
        .we_o        (muldiv_we_o),
        .waddr_o     (muldiv_waddr_o),
        .wdata_o     (muldiv_wdata_o),
        .commit_id_o (muldiv_commit_id_o)
    );

endmodule

// ==== verification/exu_tb.sv ====
// testbench for the execute unit with a random issue stream, reference model and scoreboard
`timescale 1ns/1ps

module exu_tb;
    import exu_pkg::*;

    localparam int NUM_INSTR  = 300;
    localparam int MAX_CYCLES = NUM_INSTR * 40 + 200;
    // issue to result latency of the multiply/divide port
    localparam int MUL_LAT    = 2;
    localparam int DIV_LAT    = 34;

    typedef struct packed {
        commit_id_t cid;
        reg_addr_t  rd;
        xlen_t      data;
    } wb_entry_t;

    logic       clk;
    logic       rst_n_i;
    logic       valid_i;
    exu_op_e    op_i;
    logic       use_imm_i;
    xlen_t      pc_i;
    xlen_t      imm_i;
    xlen_t      rs1_data_i;
    xlen_t      rs2_data_i;
    reg_addr_t  rd_i;
    inst_id_t   inst_id_i;
    logic       alu_wb_ready_i;
    logic       muldiv_wb_ready_i;
    logic       int_assert_i;
    xlen_t      int_addr_i;
    logic       stall_o;
    logic       alu_we_o;
    reg_addr_t  alu_waddr_o;
    xlen_t      alu_wdata_o;
    commit_id_t alu_commit_id_o;
    logic       muldiv_we_o;
    reg_addr_t  muldiv_waddr_o;
    xlen_t      muldiv_wdata_o;
    commit_id_t muldiv_commit_id_o;
    logic       jump_flag_o;
    xlen_t      jump_addr_o;

    integer    seed;
    int        errors;
    int        checks;
    int        issued;
    int        cycles = 0;
    wb_entry_t alu_q[$];
    wb_entry_t md_q[$];
    logic      alu_full;
    logic      md_full;
    int        md_wait;
    // decided at the falling edge, applied at the next rising edge
    logic      accept;
    logic      alu_take;
    logic      md_take;

    exu DUT (.*);

    function automatic logic is_alu_op(exu_op_e op);
        return op inside {ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND};
    endfunction

    function automatic logic is_jump_op(exu_op_e op);
        return (op == JAL) || (op == JALR);
    endfunction

    function automatic logic is_md_op(exu_op_e op);
        return op inside {MUL, MULH, MULHSU, MULHU, DIV, DIVU, REM, REMU};
    endfunction

    // signed less-than from the sign bits and an unsigned compare
    function automatic logic less_signed(xlen_t a, xlen_t b);
        return (a[31] != b[31]) ? a[31] : (a < b);
    endfunction

    function automatic xlen_t alu_expect(exu_op_e op, xlen_t a, xlen_t b);
        logic [4:0] sh;
        sh = b[4:0];
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            SLL:     return a << sh;
            SLT:     return {31'b0, less_signed(a, b)};
            SLTU:    return {31'b0, a < b};
            XOR:     return a ^ b;
            SRL:     return a >> sh;
            SRA:     return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
            OR:      return a | b;
            AND:     return a & b;
            default: return 32'h0;
        endcase
    endfunction

    function automatic logic branch_taken(exu_op_e op, xlen_t a, xlen_t b);
        case (op)
            BEQ:       return a == b;
            BNE:       return a != b;
            BLT:       return less_signed(a, b);
            BGE:       return !less_signed(a, b);
            BLTU:      return a < b;
            BGEU:      return !(a < b);
            JAL, JALR: return 1'b1;
            default:   return 1'b0;
        endcase
    endfunction

    function automatic xlen_t branch_target(exu_op_e op, xlen_t pc, xlen_t rs1, xlen_t imm);
        xlen_t sum;
        sum = rs1 + imm;
        if (op == JALR) begin
            return sum & 32'hffff_fffe;
        end
        return pc + imm;
    endfunction

    function automatic xlen_t muldiv_expect(exu_op_e op, xlen_t a, xlen_t b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic [63:0]        prod;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        case (op)
            MUL:    prod = {32'b0, a} * {32'b0, b};
            MULH:   prod = sa * sb;
            MULHSU: prod = sa * $signed({32'b0, b});
            MULHU:  prod = {32'b0, a} * {32'b0, b};
            // divide by zero gives all ones, remainder keeps the dividend
            DIV: begin
                if (b == 0) begin
                    prod = 64'hffff_ffff;
                end else begin
                    prod = sa / sb;
                end
            end
            DIVU:   prod = (b == 0) ? 64'hffff_ffff : {32'b0, a / b};
            REM: begin
                if (b == 0) begin
                    prod = {32'b0, a};
                end else begin
                    prod = sa % sb;
                end
            end
            REMU:   prod = (b == 0) ? {32'b0, a} : {32'b0, a % b};
            default: prod = 64'h0;
        endcase
        if (op == MUL || op inside {DIV, DIVU, REM, REMU}) begin
            return prod[31:0];
        end
        return prod[63:32];
    endfunction

    task automatic compare_word(string name, xlen_t got, xlen_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Fail %s: got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    // corner values show up often enough to hit the divider special cases
    function automatic xlen_t pick_operand();
        logic [31:0] sel;
        sel = $unsigned($random(seed)) % 20;
        case (sel)
            0:       return 32'h0;
            1:       return 32'h1;
            2:       return 32'hffff_ffff;
            3:       return 32'h8000_0000;
            4:       return 32'h7fff_ffff;
            default: return xlen_t'($random(seed));
        endcase
    endfunction

    task automatic issue_next();
        logic [31:0] code;
        exu_op_e     op;
        xlen_t       a;
        xlen_t       b;
        code = 1 + $unsigned($random(seed)) % 26;
        op   = exu_op_e'(code[4:0]);
        a    = pick_operand();
        b    = pick_operand();
        if ((op == DIV || op == REM) && ($random(seed) & 7) == 0) begin
            a = 32'h8000_0000;
            b = 32'hffff_ffff;
        end
        valid_i    <= 1'b1;
        op_i       <= op;
        use_imm_i  <= is_alu_op(op) && (($random(seed) & 1) != 0);
        pc_i       <= xlen_t'($random(seed)) & 32'hffff_fffc;
        imm_i      <= pick_operand();
        rs1_data_i <= a;
        rs2_data_i <= b;
        rd_i       <= reg_addr_t'($random(seed));
        inst_id_i  <= inst_id_t'($random(seed));
    endtask

    task automatic evaluate_cycle();
        logic alu_side;
        logic md_side;
        logic exp_stall;
        logic exp_flag;
        alu_side  = is_alu_op(op_i) || is_jump_op(op_i);
        md_side   = is_md_op(op_i);
        exp_stall = valid_i && ((alu_side && alu_full && !alu_wb_ready_i) ||
                    (md_side && (md_wait != 0 || (md_full && !muldiv_wb_ready_i))));
        accept    = valid_i && !exp_stall && !int_assert_i;
        alu_take  = alu_full && alu_wb_ready_i;
        md_take   = md_full && muldiv_wb_ready_i;
        compare_word("stall_o", xlen_t'(stall_o), xlen_t'(exp_stall));
        exp_flag = int_assert_i || (accept && branch_taken(op_i, rs1_data_i, rs2_data_i));
        compare_word("jump_flag_o", xlen_t'(jump_flag_o), xlen_t'(exp_flag));
        if (int_assert_i) begin
            compare_word("jump_addr_o", jump_addr_o, int_addr_i);
        end else if (exp_flag) begin
            compare_word("jump_addr_o", jump_addr_o,
                         branch_target(op_i, pc_i, rs1_data_i, imm_i));
        end
        // a waiting result must match the same entry every cycle
        compare_word("alu_we_o", xlen_t'(alu_we_o), xlen_t'(alu_full));
        if (alu_full && alu_q.size() != 0) begin
            compare_word("alu_wdata_o", alu_wdata_o, alu_q[0].data);
            compare_word("alu_waddr_o", xlen_t'(alu_waddr_o), xlen_t'(alu_q[0].rd));
            compare_word("alu_commit_id_o", xlen_t'(alu_commit_id_o), xlen_t'(alu_q[0].cid));
        end
        compare_word("muldiv_we_o", xlen_t'(muldiv_we_o), xlen_t'(md_full));
        if (md_full && md_q.size() != 0) begin
            compare_word("muldiv_wdata_o", muldiv_wdata_o, md_q[0].data);
            compare_word("muldiv_waddr_o", xlen_t'(muldiv_waddr_o), xlen_t'(md_q[0].rd));
            compare_word("muldiv_commit_id_o", xlen_t'(muldiv_commit_id_o),
                         xlen_t'(md_q[0].cid));
        end
    endtask

    task automatic update_model();
        wb_entry_t entry;
        if (alu_take) begin
            entry    = alu_q.pop_front();
            alu_full = 1'b0;
        end
        if (md_take) begin
            entry   = md_q.pop_front();
            md_full = 1'b0;
        end
        if (md_wait != 0) begin
            md_wait--;
            if (md_wait == 0) begin
                md_full = 1'b1;
            end
        end
        if (accept) begin
            issued++;
            entry.cid = {2'b00, inst_id_i};
            entry.rd  = rd_i;
            if (is_alu_op(op_i)) begin
                entry.data = alu_expect(op_i, rs1_data_i, use_imm_i ? imm_i : rs2_data_i);
                alu_q.push_back(entry);
                alu_full = 1'b1;
            end else if (is_jump_op(op_i)) begin
                entry.data = pc_i + 32'd4;
                alu_q.push_back(entry);
                alu_full = 1'b1;
            end else if (is_md_op(op_i)) begin
                entry.data = muldiv_expect(op_i, rs1_data_i, rs2_data_i);
                md_q.push_back(entry);
                md_wait = (op_i inside {DIV, DIVU, REM, REMU}) ? DIV_LAT - 1 : MUL_LAT - 1;
            end
        end
    endtask

    task automatic drive_inputs();
        alu_wb_ready_i    <= ($random(seed) & 3) != 0;
        muldiv_wb_ready_i <= ($random(seed) & 3) != 0;
        // rare single cycle interrupt pulses
        int_assert_i      <= ($random(seed) & 63) == 0;
        int_addr_i        <= xlen_t'($random(seed)) & 32'hffff_fffc;
        if (!valid_i || accept) begin
            if (issued < NUM_INSTR && ($random(seed) & 7) != 0) begin
                issue_next();
            end else begin
                valid_i <= 1'b0;
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            errors++;
            $display("timeout after %0d cycles with instructions still outstanding", cycles);
            $display("checks %0d errors %0d", checks, errors);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial begin
        seed              = 32'hc6e858af;
        errors            = 0;
        checks            = 0;
        issued            = 0;
        alu_full          = 1'b0;
        md_full           = 1'b0;
        md_wait           = 0;
        accept            = 1'b0;
        rst_n_i           = 1'b0;
        valid_i           = 1'b0;
        op_i              = OP_NONE;
        use_imm_i         = 1'b0;
        pc_i              = '0;
        imm_i             = '0;
        rs1_data_i        = '0;
        rs2_data_i        = '0;
        rd_i              = '0;
        inst_id_i         = '0;
        alu_wb_ready_i    = 1'b0;
        muldiv_wb_ready_i = 1'b0;
        int_assert_i      = 1'b0;
        int_addr_i        = '0;
        repeat (5) @(posedge clk);
        rst_n_i <= 1'b1;
        // idle outputs right after reset
        @(negedge clk);
        compare_word("alu_we_o", xlen_t'(alu_we_o), 32'h0);
        compare_word("muldiv_we_o", xlen_t'(muldiv_we_o), 32'h0);
        compare_word("stall_o", xlen_t'(stall_o), 32'h0);
        compare_word("jump_flag_o", xlen_t'(jump_flag_o), 32'h0);
        while (issued < NUM_INSTR || valid_i || alu_q.size() != 0 ||
               md_q.size() != 0 || md_wait != 0) begin
            @(negedge clk);
            evaluate_cycle();
            @(posedge clk);
            update_model();
            drive_inputs();
        end
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== exu_lite.f ====
+incdir+source
source/exu_pkg.sv
source/exu_dispatch.sv
source/exu_alu.sv
source/exu_bru.sv
source/exu_div.sv
source/exu_muldiv.sv
source/exu.sv
verification/exu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the execute unit testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f exu_lite.f --top-module exu_tb --Mdir build -o exu_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "verilator build failed, see build.log"
    exit 1
fi

./build/exu_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error, see sim.log"
    exit 1
fi

if grep -q "TESTS PASSED" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see sim.log"
exit 1
